//--- io_macros.svh
// --------------------------------------
// Address map and data width macros
// --------------------------------------
`ifndef IO_MACROS_SVH
`define IO_MACROS_SVH

// RV32 widths
`define XLEN              32
`define ADDR_W            32

// --------------------------------------
// Internal register window
// --------------------------------------
`define MMR_BASE          32'hFFFF_FF00        // 256 byte window up to the top of memory
`define MMR_WIN_W         8                    // Offset bits inside the window

// Register offsets within the window
`define MSIP_OFS          8'h00
`define MTIME_LO_OFS      8'h08
`define MTIME_HI_OFS      8'h0C
`define MTIMECMP_LO_OFS   8'h10
`define MTIMECMP_HI_OFS   8'h14

// --------------------------------------
// External I/O range
// --------------------------------------
`define EXT_IO_LO         32'hFFFF_0000
`define EXT_IO_HI         32'hFFFF_FEFF        // Stops just below the register window

`endif

//--- core_types_pkg.sv
// --------------------------------------
// Core word types, access size and privilege mode
// --------------------------------------
`default_nettype none

`include "io_macros.svh"

package core_types_pkg;

   // Plain vectors with a meaning
   typedef logic [`XLEN-1:0]   data_t;             // One register-sized data word
   typedef logic [`ADDR_W-1:0] addr_t;             // Byte address
   typedef logic [2*`XLEN-1:0] dword_t;            // 64 bit timer value

   // Load/store size in bytes
   typedef enum logic [2:0] {
      size_byte = 3'd1,
      size_half = 3'd2,
      size_word = 3'd4
   } ls_size_t;

   // Current privilege level of the core
   // Encoding follows the mstatus MPP field
   typedef enum logic [1:0] {
      mode_user    = 2'd0,
      mode_super   = 2'd1,
      mode_machine = 2'd3
   } priv_mode_t;

endpackage

`default_nettype wire

//--- mem_map_pkg.sv
// --------------------------------------
// Access target and timer register select
// --------------------------------------
`default_nettype none

package mem_map_pkg;

   // Where a load/store ends up
   typedef enum logic [1:0] {
      tgt_dcache,                                  // Everything not claimed below
      tgt_ext_io,                                  // External I/O port
      tgt_mmr                                      // Internal timer registers
   } target_t;

   // Register picked inside the internal window
   typedef enum logic [2:0] {
      sel_none,                                    // Unmapped offset, reads zero
      sel_msip,
      sel_mtime_lo,
      sel_mtime_hi,
      sel_mtimecmp_lo,
      sel_mtimecmp_hi
   } mmr_sel_t;

endpackage

`default_nettype wire

//--- clint_timer.sv
// --------------------------------------
// Machine timer block with msip, mtime, mtimecmp
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "io_macros.svh"

module clint_timer (
   input  logic                   clk_in,
   input  logic                   rst_n,

   // Write strobes from the router, one cycle each
   input  logic                   msip_wr,
   input  logic                   mtime_lo_wr,
   input  logic                   mtime_hi_wr,
   input  logic                   mtimecmp_lo_wr,
   input  logic                   mtimecmp_hi_wr,
   input  core_types_pkg::data_t  mmr_wr_data,

   // Register contents
   output core_types_pkg::dword_t mtime,
   output core_types_pkg::dword_t mtimecmp,
   output logic                   msip_bit,

   // Interrupt levels
   output logic                   time_irq,
   output logic                   sw_irq
);
   import core_types_pkg::*;

   dword_t mtime_nxt;                              // Next mtime value

   // --------------------------------------
   // Free running mtime
   // --------------------------------------
   always_comb begin
      mtime_nxt = mtime + 64'd1;                   // Counts every clock
      if (mtime_lo_wr) begin
         mtime_nxt[`XLEN-1:0] = mmr_wr_data;       // Write wins over the increment
      end
      if (mtime_hi_wr) begin
         mtime_nxt[2*`XLEN-1:`XLEN] = mmr_wr_data;
      end
   end

   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         mtime <= '0;
      end else begin
         mtime <= mtime_nxt;
      end
   end

   // --------------------------------------
   // Compare value and soft interrupt bit
   // --------------------------------------
   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         mtimecmp <= '1;                           // Max value keeps the timer irq quiet
         msip_bit <= 1'b0;
      end else begin
         if (mtimecmp_lo_wr) begin
            mtimecmp[`XLEN-1:0] <= mmr_wr_data;
         end
         if (mtimecmp_hi_wr) begin
            mtimecmp[2*`XLEN-1:`XLEN] <= mmr_wr_data;
         end
         if (msip_wr) begin
            msip_bit <= mmr_wr_data[0];            // Only bit 0 is implemented
         end
      end
   end

   // Interrupt levels straight from the registers
   assign time_irq = (mtime >= mtimecmp);          // Unsigned 64 bit compare
   assign sw_irq   = msip_bit;

endmodule

`default_nettype wire

//--- mem_io_router.sv
// --------------------------------------
// Load/store router to data cache, I/O and timer registers
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "io_macros.svh"

module mem_io_router (
   input  logic                       clk_in,
   input  logic                       rst_n,
   input  core_types_pkg::priv_mode_t mode,

   // Request from the memory stage, held until acked
   input  logic                       mio_req,
   input  logic                       mio_rd,
   input  logic                       mio_wr,
   input  logic                       mio_zero_ext,
   input  core_types_pkg::addr_t      mio_addr,
   input  core_types_pkg::data_t      mio_wr_data,
   input  core_types_pkg::ls_size_t   mio_size,
   output logic                       mio_ack,
   output logic                       mio_ack_fault,
   output core_types_pkg::data_t      mio_rd_data,

   // L1 data cache
   output logic                       dc_req,
   output logic                       dc_rd,
   output logic                       dc_wr,
   output logic                       dc_zero_ext,
   output core_types_pkg::addr_t      dc_rw_addr,
   output core_types_pkg::data_t      dc_wr_data,
   output core_types_pkg::ls_size_t   dc_size,
   input  logic                       dc_ack,
   input  core_types_pkg::data_t      dc_ack_data,

   // External I/O
   output logic                       io_req,
   output logic                       io_rd,
   output logic                       io_wr,
   output core_types_pkg::addr_t      io_addr,
   output core_types_pkg::data_t      io_wr_data,
   input  logic                       io_ack,
   input  logic                       io_ack_fault,
   input  core_types_pkg::data_t      io_rd_data,

   // Timer block
   output logic                       msip_wr,
   output logic                       mtime_lo_wr,
   output logic                       mtime_hi_wr,
   output logic                       mtimecmp_lo_wr,
   output logic                       mtimecmp_hi_wr,
   output core_types_pkg::data_t      mmr_wr_data,
   input  core_types_pkg::dword_t     mtime,
   input  core_types_pkg::dword_t     mtimecmp,
   input  logic                       msip_bit
);
   import core_types_pkg::*;
   import mem_map_pkg::*;

   target_t  tgt;                                  // Decoded destination
   mmr_sel_t mmr_sel;                              // Decoded timer register
   logic     mmr_start;                            // First cycle of a register access
   logic     mmr_user;                             // Register access from user mode
   logic     mmr_wr_ok;                            // Register write allowed
   logic     mmr_pend;                             // Access taken, waiting for req to drop
   logic     mmr_ack;
   logic     mmr_fault;
   data_t    mmr_rd_nxt;                           // Register contents selected this cycle
   data_t    mmr_rd_data;                          // Registered read data

   // --------------------------------------
   // Address decode
   // --------------------------------------
   always_comb begin
      if (mio_addr >= `MMR_BASE) begin            // Window runs to the top of memory
         tgt = tgt_mmr;
      end else if ((mio_addr >= `EXT_IO_LO) && (mio_addr <= `EXT_IO_HI)) begin
         tgt = tgt_ext_io;
      end else begin
         tgt = tgt_dcache;
      end
   end

   always_comb begin
      case (mio_addr[`MMR_WIN_W-1:0])
         `MSIP_OFS:        mmr_sel = sel_msip;
         `MTIME_LO_OFS:    mmr_sel = sel_mtime_lo;
         `MTIME_HI_OFS:    mmr_sel = sel_mtime_hi;
         `MTIMECMP_LO_OFS: mmr_sel = sel_mtimecmp_lo;
         `MTIMECMP_HI_OFS: mmr_sel = sel_mtimecmp_hi;
         default:          mmr_sel = sel_none;     // Hole in the window
      endcase
   end

   // Cache and I/O see the request only when it is theirs
   assign dc_req      = mio_req & (tgt == tgt_dcache);
   assign dc_rw_addr  = mio_addr;
   assign dc_rd       = mio_rd;
   assign dc_wr       = mio_wr;
   assign dc_wr_data  = mio_wr_data;
   assign dc_size     = mio_size;
   assign dc_zero_ext = mio_zero_ext;

   assign io_req      = mio_req & (tgt == tgt_ext_io);
   assign io_addr     = mio_addr;
   assign io_rd       = mio_rd;
   assign io_wr       = mio_wr;
   assign io_wr_data  = mio_wr_data;

   // --------------------------------------
   // Internal register access
   // --------------------------------------
   assign mmr_start = mio_req & (tgt == tgt_mmr) & ~mmr_pend;   // Accept once
   assign mmr_user  = (mode == mode_user);
   assign mmr_wr_ok = mmr_start & mio_wr & ~mmr_user;          // User writes are dropped

   // One-cycle strobes toward the timer block
   assign msip_wr        = mmr_wr_ok & (mmr_sel == sel_msip);
   assign mtime_lo_wr    = mmr_wr_ok & (mmr_sel == sel_mtime_lo);
   assign mtime_hi_wr    = mmr_wr_ok & (mmr_sel == sel_mtime_hi);
   assign mtimecmp_lo_wr = mmr_wr_ok & (mmr_sel == sel_mtimecmp_lo);
   assign mtimecmp_hi_wr = mmr_wr_ok & (mmr_sel == sel_mtimecmp_hi);
   assign mmr_wr_data    = mio_wr_data;

   always_comb begin
      case (mmr_sel)
         sel_msip:        mmr_rd_nxt = {{(`XLEN-1){1'b0}}, msip_bit};
         sel_mtime_lo:    mmr_rd_nxt = mtime[`XLEN-1:0];
         sel_mtime_hi:    mmr_rd_nxt = mtime[2*`XLEN-1:`XLEN];
         sel_mtimecmp_lo: mmr_rd_nxt = mtimecmp[`XLEN-1:0];
         sel_mtimecmp_hi: mmr_rd_nxt = mtimecmp[2*`XLEN-1:`XLEN];
         default:         mmr_rd_nxt = '0;
      endcase
   end

   // Ack one cycle after the first request cycle
   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         mmr_pend  <= 1'b0;
         mmr_ack   <= 1'b0;
         mmr_fault <= 1'b0;
      end else begin
         mmr_ack   <= mmr_start;
         mmr_fault <= mmr_start & mmr_user;
         if (mmr_start) begin
            mmr_pend <= 1'b1;
         end else if (!mio_req) begin
            mmr_pend <= 1'b0;                      // Requester let go after the ack
         end
      end
   end

   always_ff @(posedge clk_in) begin
      if (mmr_start) begin
         mmr_rd_data <= (mio_rd && !mmr_user) ? mmr_rd_nxt : '0;
      end
   end

   // --------------------------------------
   // Response mux back to the requester
   // --------------------------------------
   always_comb begin
      case (tgt)
         tgt_ext_io: begin
            mio_ack       = io_ack;
            mio_ack_fault = io_ack_fault;
            mio_rd_data   = io_rd_data;
         end
         tgt_mmr: begin
            mio_ack       = mmr_ack;
            mio_ack_fault = mmr_fault;
            mio_rd_data   = mmr_rd_data;
         end
         default: begin                            // Data cache never faults
            mio_ack       = dc_ack;
            mio_ack_fault = 1'b0;
            mio_rd_data   = dc_ack_data;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- mem_io_top.sv
// --------------------------------------
// Memory and I/O side top with router and timer
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_io_top (
   input  logic                       clk_in,
   input  logic                       rst_n,
   input  core_types_pkg::priv_mode_t mode,          // Current privilege level

   // Memory stage request
   input  logic                       mio_req,
   input  logic                       mio_rd,
   input  logic                       mio_wr,
   input  logic                       mio_zero_ext,
   input  core_types_pkg::addr_t      mio_addr,
   input  core_types_pkg::data_t      mio_wr_data,
   input  core_types_pkg::ls_size_t   mio_size,
   output logic                       mio_ack,
   output logic                       mio_ack_fault,
   output core_types_pkg::data_t      mio_rd_data,

   // L1 data cache
   output logic                       dc_req,
   output logic                       dc_rd,
   output logic                       dc_wr,
   output logic                       dc_zero_ext,
   output core_types_pkg::addr_t      dc_rw_addr,
   output core_types_pkg::data_t      dc_wr_data,
   output core_types_pkg::ls_size_t   dc_size,
   input  logic                       dc_ack,
   input  core_types_pkg::data_t      dc_ack_data,

   // External I/O
   output logic                       io_req,
   output logic                       io_rd,
   output logic                       io_wr,
   output core_types_pkg::addr_t      io_addr,
   output core_types_pkg::data_t      io_wr_data,
   input  logic                       io_ack,
   input  logic                       io_ack_fault,
   input  core_types_pkg::data_t      io_rd_data,

   // Interrupts toward the core
   output logic                       time_irq,
   output logic                       sw_irq
);
   import core_types_pkg::*;

   // --------------------------------------
   // Router to timer wiring
   // --------------------------------------
   logic   msip_wr;
   logic   mtime_lo_wr;
   logic   mtime_hi_wr;
   logic   mtimecmp_lo_wr;
   logic   mtimecmp_hi_wr;
   data_t  mmr_wr_data;                            // Shared write data for all strobes
   dword_t mtime;
   dword_t mtimecmp;
   logic   msip_bit;

   mem_io_router ROUTER (
      .clk_in(clk_in), .rst_n(rst_n), .mode(mode),
      .mio_req(mio_req), .mio_rd(mio_rd), .mio_wr(mio_wr), .mio_zero_ext(mio_zero_ext),
      .mio_addr(mio_addr), .mio_wr_data(mio_wr_data), .mio_size(mio_size),
      .mio_ack(mio_ack), .mio_ack_fault(mio_ack_fault), .mio_rd_data(mio_rd_data),
      .dc_req(dc_req), .dc_rd(dc_rd), .dc_wr(dc_wr), .dc_zero_ext(dc_zero_ext),
      .dc_rw_addr(dc_rw_addr), .dc_wr_data(dc_wr_data), .dc_size(dc_size),
      .dc_ack(dc_ack), .dc_ack_data(dc_ack_data),
      .io_req(io_req), .io_rd(io_rd), .io_wr(io_wr), .io_addr(io_addr),
      .io_wr_data(io_wr_data), .io_ack(io_ack), .io_ack_fault(io_ack_fault),
      .io_rd_data(io_rd_data),
      .msip_wr(msip_wr), .mtime_lo_wr(mtime_lo_wr), .mtime_hi_wr(mtime_hi_wr),
      .mtimecmp_lo_wr(mtimecmp_lo_wr), .mtimecmp_hi_wr(mtimecmp_hi_wr),
      .mmr_wr_data(mmr_wr_data),
      .mtime(mtime), .mtimecmp(mtimecmp), .msip_bit(msip_bit)    // Read path
   );

   // Timer registers and interrupt levels
   clint_timer CLINT (
      .clk_in(clk_in), .rst_n(rst_n),
      .msip_wr(msip_wr), .mtime_lo_wr(mtime_lo_wr), .mtime_hi_wr(mtime_hi_wr),
      .mtimecmp_lo_wr(mtimecmp_lo_wr), .mtimecmp_hi_wr(mtimecmp_hi_wr),
      .mmr_wr_data(mmr_wr_data),
      .mtime(mtime), .mtimecmp(mtimecmp), .msip_bit(msip_bit),
      .time_irq(time_irq), .sw_irq(sw_irq)
   );

endmodule

`default_nettype wire

//--- tb_mem_io_top.sv
// ----------------------------------------
// Testbench for mem_io_top with cache and I/O responders
// Replays access vectors and checks routing, timer and interrupts
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "io_macros.svh"

module tb_mem_io_top;
   import core_types_pkg::*;
   import mem_map_pkg::*;

   localparam int    VEC_W    = 9;                 // Words per vector line
   localparam int    MAX_VEC  = 64;
   localparam int    TIMEOUT  = 50;                // Cycles allowed for one ack
   localparam data_t END_MARK = 32'h0000_000F;     // Mode word that ends the list
   localparam addr_t MMR_WIN_SIZE = 32'd256;       // Register window size in bytes

   logic clk_in, rst_n, mio_req, mio_rd, mio_wr, mio_zero_ext;
   logic mio_ack, mio_ack_fault, dc_req, dc_rd, dc_wr, dc_zero_ext, dc_ack;
   logic io_req, io_rd, io_wr, io_ack, io_ack_fault, time_irq, sw_irq;
   priv_mode_t mode;
   addr_t      mio_addr, dc_rw_addr, io_addr;
   data_t      mio_wr_data, mio_rd_data, dc_wr_data, dc_ack_data, io_wr_data, io_rd_data;
   ls_size_t   mio_size, dc_size;

   data_t  vec_mem [0:VEC_W*MAX_VEC-1];            // Flat copy of the stimulus file
   int     err_cnt, tmo_cnt;
   integer seed;
   int     rsp_delay;                              // Responder wait for the current vector
   data_t  rsp_data;
   logic   rsp_fault;
   data_t  last_mtime;                             // Previous MTIME_LO sample
   logic   abort;

   mem_io_top DUT (.*);

   initial begin : clock_gen
      clk_in = 1'b0;
      forever #4 clk_in = ~clk_in;                 // 8 ns period
   end

   // ----------------------------------------
   // Data cache and I/O responders
   // ----------------------------------------
   initial begin : dc_responder
      dc_ack      = 1'b0;
      dc_ack_data = '0;
      forever begin
         @(negedge clk_in);
         if (dc_req) begin
            repeat (rsp_delay) @(posedge clk_in);
            @(posedge clk_in);
            #1;
            dc_ack      = 1'b1;                    // One cycle ack with data
            dc_ack_data = rsp_data;
            @(posedge clk_in);
            #1;
            dc_ack      = 1'b0;
         end
      end
   end

   initial begin : io_responder
      io_ack       = 1'b0;
      io_ack_fault = 1'b0;
      io_rd_data   = '0;
      forever begin
         @(negedge clk_in);
         if (io_req) begin
            repeat (rsp_delay) @(posedge clk_in);
            @(posedge clk_in);
            #1;
            io_ack       = 1'b1;
            io_ack_fault = rsp_fault;              // Fault flag straight from the vector
            io_rd_data   = rsp_data;
            @(posedge clk_in);
            #1;
            io_ack       = 1'b0;
            io_ack_fault = 1'b0;
         end
      end
   end

   // ----------------------------------------
   // Compare helpers
   // ----------------------------------------
   task automatic compare_word(input string name, input data_t exp, input data_t act);
      assert (act == exp) else begin
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic compare_bit(input string name, input logic exp, input logic act);
      assert (act == exp) else begin
         $display("ERR %s: expected %b, actual %b", name, exp, act);
         err_cnt++;
      end
   endtask

   // Destination by the address map
   function automatic target_t target_of(input addr_t a);
      if ((a - `MMR_BASE) < MMR_WIN_SIZE) begin   // Offset wraps for addresses below the base
         return tgt_mmr;
      end else if ((a >= `EXT_IO_LO) && (a <= `EXT_IO_HI)) begin
         return tgt_ext_io;
      end
      return tgt_dcache;
   endfunction

   // Request fields must show up unchanged on the chosen port
   task automatic verify_passthrough(input int idx, input target_t tgt);
      string tag;
      tag = $sformatf("vec %0d", idx);
      if (tgt == tgt_dcache) begin
         compare_word({tag, " dc_rw_addr"}, mio_addr, dc_rw_addr);
         compare_word({tag, " dc_wr_data"}, mio_wr_data, dc_wr_data);
         compare_word({tag, " dc_size"}, {29'd0, mio_size}, {29'd0, dc_size});
         compare_bit({tag, " dc_zero_ext"}, mio_zero_ext, dc_zero_ext);
         compare_bit({tag, " dc_rd"}, mio_rd, dc_rd);
         compare_bit({tag, " dc_wr"}, mio_wr, dc_wr);
      end else if (tgt == tgt_ext_io) begin
         compare_word({tag, " io_addr"}, mio_addr, io_addr);
         compare_word({tag, " io_wr_data"}, mio_wr_data, io_wr_data);
         compare_bit({tag, " io_rd"}, mio_rd, io_rd);
         compare_bit({tag, " io_wr"}, mio_wr, io_wr);
      end else begin
         compare_bit({tag, " early mio_ack"}, 1'b0, mio_ack);   // Registered ack only
      end
   endtask

   // ----------------------------------------
   // One access from a vector line
   // ----------------------------------------
   task automatic run_vector(input int idx);
      int      base;
      int      cycles;
      logic    acked;
      data_t   op, exp_data, exp_flags, pick;
      target_t tgt;
      base      = idx * VEC_W;
      op        = vec_mem[base+1];
      exp_data  = vec_mem[base+7];
      exp_flags = vec_mem[base+8];                 // Bit 0 fault, bit 1 time_irq, bit 2 sw_irq
      tgt       = target_of(vec_mem[base+2]);
      @(posedge clk_in);
      #1;
      pick         = $random(seed);                // Size and zero-extend pick
      rsp_delay    = int'(vec_mem[base+4]);
      rsp_data     = (op == 32'd1) ? data_t'($random(seed)) : vec_mem[base+5];
      rsp_fault    = vec_mem[base+6][0];
      mode         = priv_mode_t'(vec_mem[base][1:0]);
      mio_addr     = vec_mem[base+2];
      mio_wr_data  = vec_mem[base+3];
      mio_rd       = (op != 32'd1);
      mio_wr       = (op == 32'd1);
      mio_zero_ext = pick[2];
      case (pick[1:0])
         2'd0:    mio_size = size_byte;
         2'd1:    mio_size = size_half;
         default: mio_size = size_word;
      endcase
      mio_req      = 1'b1;
      cycles = 0;
      acked  = 1'b0;
      while (!acked && (cycles < TIMEOUT)) begin
         @(negedge clk_in);
         cycles++;
         compare_bit($sformatf("vec %0d dc_req", idx), tgt == tgt_dcache, dc_req);
         compare_bit($sformatf("vec %0d io_req", idx), tgt == tgt_ext_io, io_req);
         if (cycles == 1) begin
            verify_passthrough(idx, tgt);
         end
         acked = mio_ack;
      end
      if (!acked) begin
         $display("vector %0d got no ack within %0d cycles", idx, TIMEOUT);
         tmo_cnt++;
         abort = 1'b1;
      end else begin
         if (tgt == tgt_mmr) begin
            compare_word($sformatf("vec %0d ack latency", idx), 32'd2, data_t'(cycles));
         end
         if (op == 32'd2) begin
            assert (mio_rd_data > last_mtime) else begin
               $display("ERR vec %0d mtime_lo: expected above %h, actual %h",
                        idx, last_mtime, mio_rd_data);
               err_cnt++;
            end
            last_mtime = mio_rd_data;
         end else if (op == 32'd0) begin
            compare_word($sformatf("vec %0d rd_data", idx), exp_data, mio_rd_data);
         end
         compare_bit($sformatf("vec %0d ack_fault", idx), exp_flags[0], mio_ack_fault);
         compare_bit($sformatf("vec %0d time_irq", idx), exp_flags[1], time_irq);
         compare_bit($sformatf("vec %0d sw_irq", idx), exp_flags[2], sw_irq);
      end
      @(posedge clk_in);
      #1;
      mio_req = 1'b0;                              // Drop in the cycle after the ack
      @(negedge clk_in);
      compare_bit($sformatf("vec %0d ack after drop", idx), 1'b0, mio_ack);
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin : main_seq
      int nvec;
      rst_n        = 1'b0;
      mode         = mode_machine;
      mio_req      = 1'b0;
      mio_rd       = 1'b0;
      mio_wr       = 1'b0;
      mio_zero_ext = 1'b0;
      mio_addr     = '0;
      mio_wr_data  = '0;
      mio_size     = size_word;
      rsp_delay    = 0;
      rsp_data     = '0;
      rsp_fault    = 1'b0;
      seed         = 32'hf8405a74;
      err_cnt      = 0;
      tmo_cnt      = 0;
      last_mtime   = '0;
      abort        = 1'b0;
      $readmemh("mem_io_stimulus.txt", vec_mem);

      repeat (9) @(posedge clk_in);
      @(negedge clk_in);
      compare_bit("reset dc_req", 1'b0, dc_req);
      compare_bit("reset io_req", 1'b0, io_req);
      compare_bit("reset mio_ack", 1'b0, mio_ack);
      compare_bit("reset time_irq", 1'b0, time_irq);
      compare_bit("reset sw_irq", 1'b0, sw_irq);
      @(posedge clk_in);
      #1;
      rst_n = 1'b1;                                // Released after 10 cycles

      nvec = 0;
      while ((nvec < MAX_VEC) && (vec_mem[nvec*VEC_W] != END_MARK) && !abort) begin
         run_vector(nvec);
         nvec++;
      end
      if (nvec == MAX_VEC) begin
         $display("stimulus file has no end marker");
         err_cnt++;
      end

      $display("errors: %0d value, %0d timeout", err_cnt, tmo_cnt);
      if ((err_cnt == 0) && (tmo_cnt == 0)) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- mem_io_stimulus.txt
// mode op addr wdata delay rsp_data rsp_fault exp_data exp_flags (all hex)
// op 0 read, 1 write, 2 rising mtime read; flags bit0 fault, bit1 time_irq, bit2 sw_irq
// Reset values of mtimecmp
3 0 FFFFFF10 00000000 0 00000000 0 FFFFFFFF 0
3 0 FFFFFF14 00000000 0 00000000 0 FFFFFFFF 0
// Data cache routing
3 1 00001000 CAFEF00D 2 00000000 0 00000000 0
3 0 00001004 00000000 3 12345678 0 12345678 0
0 0 00002000 00000000 0 A5A55A5A 0 A5A55A5A 0
3 0 7FFFFFFC 00000000 5 0BADBEEF 0 0BADBEEF 0
3 0 FFFEFFFC 00000000 1 11223344 0 11223344 0
// External I/O routing
3 1 FFFF0000 55AA55AA 1 00000000 0 00000000 0
3 0 FFFF0010 00000000 2 87654321 0 87654321 0
3 0 FFFFFEFC 00000000 4 DEADC0DE 1 DEADC0DE 1
0 0 FFFF8000 00000000 0 00C0FFEE 0 00C0FFEE 0
// Timer registers, mtimecmp and msip
3 1 FFFFFF14 12345678 0 00000000 0 00000000 0
3 1 FFFFFF10 9ABCDEF0 0 00000000 0 00000000 0
3 0 FFFFFF14 00000000 0 00000000 0 12345678 0
3 0 FFFFFF10 00000000 0 00000000 0 9ABCDEF0 0
3 1 FFFFFF00 FFFFFFFF 0 00000000 0 00000000 4
3 0 FFFFFF00 00000000 0 00000000 0 00000001 4
3 0 FFFFFF40 00000000 0 00000000 0 00000000 4
// User mode faults
0 1 FFFFFF00 00000000 0 00000000 0 00000000 5
3 0 FFFFFF00 00000000 0 00000000 0 00000001 4
0 0 FFFFFF10 00000000 0 00000000 0 00000000 5
3 1 FFFFFF00 00000002 0 00000000 0 00000000 0
3 0 FFFFFF00 00000000 0 00000000 0 00000000 0
// Free running mtime
3 2 FFFFFF08 00000000 0 00000000 0 00000000 0
3 2 FFFFFF08 00000000 0 00000000 0 00000000 0
3 2 FFFFFF08 00000000 0 00000000 0 00000000 0
// Timer interrupt on and off
3 1 FFFFFF14 00000000 0 00000000 0 00000000 0
3 1 FFFFFF10 00000000 0 00000000 0 00000000 2
3 0 FFFFFF10 00000000 0 00000000 0 00000000 2
3 1 FFFFFF14 FFFFFFFF 0 00000000 0 00000000 0
3 1 FFFFFF10 FFFFFFFF 0 00000000 0 00000000 0
3 0 FFFFFF0C 00000000 0 00000000 0 00000000 0
// End of list
F 0 00000000 00000000 0 00000000 0 00000000 0

//--- sources.f
+incdir+.
core_types_pkg.sv
mem_map_pkg.sv
clint_timer.sv
mem_io_router.sv
mem_io_top.sv
tb_mem_io_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mem_io_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      -f sources.f --top-module tb_mem_io_top -o sim_tb; then
   echo "Verilator build failed"
   exit 1
fi

if ! ./obj_dir/sim_tb > "$LOG" 2>&1; then
   cat "$LOG"
   echo "Simulation exited with an error"
   exit 1
fi

cat "$LOG"

# Pass only when the testbench printed its pass line
if grep -qx "test passed" "$LOG"; then
   exit 0
fi
echo "Pass line not found in $LOG"
exit 1
